// ==== compile.f ====
source/hpdcache_ctrl_pkg.sv
source/hpdcache_st1_if.sv
source/hpdcache_rtab_if.sv
source/hpdcache_req_arbiter.sv
source/hpdcache_st1_ctrl.sv
source/hpdcache_rtab.sv
source/hpdcache_evt_counters.sv
source/hpdcache_ctrl_top.sv
dv/hpdcache_ctrl_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the control engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module hpdcache_ctrl_tb -o sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" sim.log; then
    exit 1
fi
if ! grep -q "Regression passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

// ==== dv/hpdcache_ctrl_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench of the data cache control engine
// Clock, reset, core/refill/uncacheable stimulus
// Directory model, miss order scoreboard, concurrent checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module hpdcache_ctrl_tb;
    import hpdcache_ctrl_pkg::*;

    localparam int TIMEOUT = 200;

    logic clk = 1'b0;
    logic rst_n_i;
    logic core_req_valid_i, core_req_ready_o;
    logic [3:0] core_req_id_i;
    logic core_req_is_load_i, core_req_is_store_i, core_req_is_uncacheable_i;
    logic core_req_need_rsp_i;
    logic refill_req_valid_i, refill_req_ready_o;
    logic dir_init_ready_i, dir_lookup_valid_o;
    logic [3:0] dir_lookup_id_o;
    logic dir_hit_i, mshr_hit_i, mshr_full_i;
    logic rsp_valid_o, uc_req_valid_o, uc_done_i, miss_req_valid_o;
    logic [3:0] rsp_id_o, uc_req_id_o, miss_req_id_o;
    logic data_write_o, rtab_full_o;
    hpdcache_evt_e evt_sel_i;
    logic [15:0] evt_count_o;

    int   err_cnt = 0;
    int   test_cnt = 0;
    int   exp_read = 0, exp_write = 0, exp_rmiss = 0, exp_hold = 0, exp_uc = 0;
    int   seed = 71;
    logic hit_n;
    logic uc_wait_q;
    logic [3:0] miss_q[$];

    always #50 clk = ~clk;

    hpdcache_ctrl_top hpdcache_ctrl_top_inst (
        .clk_i(clk), .rst_n_i, .core_req_valid_i, .core_req_ready_o, .core_req_id_i,
        .core_req_is_load_i, .core_req_is_store_i, .core_req_is_uncacheable_i,
        .core_req_need_rsp_i, .refill_req_valid_i, .refill_req_ready_o, .dir_init_ready_i,
        .dir_lookup_valid_o, .dir_lookup_id_o, .dir_hit_i, .mshr_hit_i, .mshr_full_i,
        .rsp_valid_o, .rsp_id_o, .uc_req_valid_o, .uc_req_id_o, .uc_done_i,
        .miss_req_valid_o, .miss_req_id_o, .data_write_o, .rtab_full_o,
        .evt_sel_i, .evt_count_o
    );

    task automatic report_error(input string msg);
        err_cnt++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    // Directory answers one cycle after the lookup, odd ids hit
    always begin
        @(negedge clk);
        hit_n = dir_lookup_valid_o & dir_lookup_id_o[0];
        @(posedge clk);
        #10;
        dir_hit_i = hit_n;
    end

    // Outstanding uncacheable request seen from outside
    always @(posedge clk) begin
        if (!rst_n_i || uc_done_i) begin
            uc_wait_q <= 1'b0;
        end else if (uc_req_valid_o) begin
            uc_wait_q <= 1'b1;
        end
    end

    // Miss requests leave in accept order
    always @(negedge clk) begin
        if (rst_n_i && miss_req_valid_o) begin
            if (miss_q.size() == 0) begin
                report_error($sformatf("unexpected miss request id %0d", miss_req_id_o));
            end else if (miss_q[0] != miss_req_id_o) begin
                report_error($sformatf("miss id %0d, expected %0d", miss_req_id_o, miss_q[0]));
                void'(miss_q.pop_front());
            end else begin
                void'(miss_q.pop_front());
            end
        end
    end

    wire acc = core_req_valid_i & core_req_ready_o;
    wire acc_ld = acc & core_req_is_load_i & ~core_req_is_uncacheable_i;
    wire acc_st = acc & core_req_is_store_i & ~core_req_is_uncacheable_i;

    a_init: assert property (@(posedge clk) disable iff (!rst_n_i)
        !dir_init_ready_i |-> !core_req_ready_o)
        else report_error("core ready before directory init");
    a_ld_hit: assert property (@(posedge clk) disable iff (!rst_n_i)
        acc_ld && core_req_id_i[0] && core_req_need_rsp_i |=>
            rsp_valid_o && rsp_id_o == $past(core_req_id_i))
        else report_error("load hit response missing or wrong id");
    a_ld_miss: assert property (@(posedge clk) disable iff (!rst_n_i)
        acc_ld && !core_req_id_i[0] && !mshr_hit_i |=> !rsp_valid_o ##1
            (miss_req_valid_o && miss_req_id_o == $past(core_req_id_i, 2)))
        else report_error("load miss request missing or response seen");
    a_uc_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        acc && core_req_is_uncacheable_i |=>
            uc_req_valid_o && uc_req_id_o == $past(core_req_id_i))
        else report_error("uncacheable request missing or wrong id");
    a_uc_block: assert property (@(posedge clk) disable iff (!rst_n_i)
        (uc_req_valid_o || uc_wait_q) |-> !core_req_ready_o)
        else report_error("core ready during uncacheable wait");
    a_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        acc_ld && !core_req_id_i[0] && mshr_hit_i |=> !rsp_valid_o ##1 !miss_req_valid_o)
        else report_error("held load produced an output");
    a_full: assert property (@(posedge clk) disable iff (!rst_n_i)
        rtab_full_o |-> !core_req_ready_o)
        else report_error("core ready with full replay table");
    a_st_hit: assert property (@(posedge clk) disable iff (!rst_n_i)
        acc_st && core_req_id_i[0] |=> data_write_o && rsp_valid_o)
        else report_error("store hit without write or response");
    a_st_miss: assert property (@(posedge clk) disable iff (!rst_n_i)
        acc_st && !core_req_id_i[0] && !mshr_hit_i |=> !data_write_o && rsp_valid_o)
        else report_error("store miss response wrong");
    a_refill: assert property (@(posedge clk) disable iff (!rst_n_i)
        refill_req_ready_o |-> !$past(dir_lookup_valid_o) && !miss_req_valid_o)
        else report_error("refill granted with busy pipeline");

    // Offer one request and wait for its transfer
    task automatic send_req(input logic [3:0] id, input logic ld, input logic st,
                            input logic uc);
        int n;
        @(posedge clk);
        #10;
        core_req_valid_i = 1'b1;
        core_req_id_i = id;
        core_req_is_load_i = ld;
        core_req_is_store_i = st;
        core_req_is_uncacheable_i = uc;
        core_req_need_rsp_i = 1'b1;
        n = 0;
        @(negedge clk);
        while (!core_req_ready_o && n < TIMEOUT) begin
            n++;
            @(negedge clk);
        end
        if (n == TIMEOUT) begin
            err_cnt++;
            $display("Timeout: core request id %0d was never accepted", id);
        end
        @(posedge clk);
        #10;
        core_req_valid_i = 1'b0;
    endtask

    // Raise a refill right away, even behind a request still in flight
    task automatic do_refill();
        int n;
        refill_req_valid_i = 1'b1;
        n = 0;
        @(negedge clk);
        while (!refill_req_ready_o && n < TIMEOUT) begin
            n++;
            @(negedge clk);
        end
        if (n == TIMEOUT) begin
            err_cnt++;
            $display("Timeout: refill was never accepted");
        end
        @(posedge clk);
        #10;
        refill_req_valid_i = 1'b0;
    endtask

    // Waits until the given flag reaches a level, sampled at falling edges
    task automatic wait_level(ref logic sig, input logic lvl, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (sig !== lvl && n < TIMEOUT) begin
            n++;
            @(negedge clk);
        end
        if (n == TIMEOUT) begin
            err_cnt++;
            $display("Timeout: %s never happened", what);
        end
    endtask

    task automatic wait_miss_drain();
        int n;
        n = 0;
        while (miss_q.size() != 0 && n < TIMEOUT) begin
            n++;
            @(negedge clk);
        end
        if (n == TIMEOUT) begin
            err_cnt++;
            $display("Timeout: %0d miss requests never came out", miss_q.size());
        end
    endtask

    task automatic check_count(input hpdcache_evt_e sel, input int exp);
        @(posedge clk);
        #10;
        evt_sel_i = sel;
        @(negedge clk);
        if (evt_count_o != 16'(exp)) begin
            report_error($sformatf("event %s count %0d, expected %0d", sel.name(),
                                   evt_count_o, exp));
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        test_cnt++;
        $display("Test %0d %s: %0d errors", test_cnt, name, err_cnt - err_before);
    endtask

    initial begin
        int e;
        logic [3:0] rid;
        rst_n_i = 1'b0;
        core_req_valid_i = 1'b0;
        core_req_id_i = '0;
        core_req_is_load_i = 1'b0;
        core_req_is_store_i = 1'b0;
        core_req_is_uncacheable_i = 1'b0;
        core_req_need_rsp_i = 1'b0;
        refill_req_valid_i = 1'b0;
        dir_init_ready_i = 1'b0;
        dir_hit_i = 1'b0;
        mshr_hit_i = 1'b0;
        mshr_full_i = 1'b0;
        uc_done_i = 1'b0;
        evt_sel_i = EVT_READ;
        repeat (4) @(posedge clk);
        #10;
        rst_n_i = 1'b1;

        // Directory still initialising
        e = err_cnt;
        repeat (5) @(posedge clk);
        #10;
        dir_init_ready_i = 1'b1;
        end_test("init wait", e);

        e = err_cnt;
        send_req(4'd3, 1'b1, 1'b0, 1'b0);
        exp_read++;
        send_req(4'd4, 1'b1, 1'b0, 1'b0);
        exp_read++;
        exp_rmiss++;
        miss_q.push_back(4'd4);
        for (int i = 0; i < 6; i++) begin
            rid = 4'($random(seed));
            send_req(rid, 1'b1, 1'b0, 1'b0);
            exp_read++;
            if (!rid[0]) begin
                exp_rmiss++;
                miss_q.push_back(rid);
            end
        end
        wait_miss_drain();
        end_test("load hit and miss", e);

        e = err_cnt;
        send_req(4'd5, 1'b1, 1'b0, 1'b1);
        exp_uc++;
        wait_level(uc_req_valid_o, 1'b1, "uncacheable request");
        repeat (3) @(posedge clk);
        #10;
        uc_done_i = 1'b1;
        @(posedge clk);
        #10;
        uc_done_i = 1'b0;
        end_test("uncacheable", e);

        e = err_cnt;
        mshr_hit_i = 1'b1;
        for (int i = 1; i <= 4; i++) begin
            send_req(4'(2 * i), 1'b1, 1'b0, 1'b0);
            exp_hold++;
            exp_read++;
            exp_rmiss++;
            miss_q.push_back(4'(2 * i));
        end
        wait_level(rtab_full_o, 1'b1, "replay table full");
        repeat (3) @(posedge clk);
        #10;
        mshr_hit_i = 1'b0;
        do_refill();
        wait_level(rtab_full_o, 1'b0, "replay table drain");
        wait_miss_drain();
        end_test("replay table", e);

        e = err_cnt;
        send_req(4'd7, 1'b0, 1'b1, 1'b0);
        exp_write++;
        send_req(4'd6, 1'b0, 1'b1, 1'b0);
        exp_write++;
        // Load miss still in stage 1 when the refill is raised
        send_req(4'd10, 1'b1, 1'b0, 1'b0);
        exp_read++;
        exp_rmiss++;
        miss_q.push_back(4'd10);
        do_refill();
        wait_miss_drain();
        repeat (8) @(posedge clk);
        end_test("store and refill", e);

        e = err_cnt;
        check_count(EVT_READ, exp_read);
        check_count(EVT_WRITE, exp_write);
        check_count(EVT_READ_MISS, exp_rmiss);
        check_count(EVT_ON_HOLD, exp_hold);
        check_count(EVT_UNCACHED, exp_uc);
        end_test("event counters", e);

        $display("Tests run: %0d, errors: %0d", test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== source/hpdcache_ctrl_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data cache control engine top level
// Arbiter, stage-1 controller, replay table, event counters
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module hpdcache_ctrl_top #(
    parameter int RTAB_DEPTH    = 4,
    parameter int EVT_CNT_WIDTH = 16,
    parameter int REFILL_CYCLES = hpdcache_ctrl_pkg::REFILL_CYCLES_DEFAULT
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                core_req_valid_i,
    output logic                                core_req_ready_o,
    input  hpdcache_ctrl_pkg::hpdcache_req_id_t  core_req_id_i,
    input  logic                                core_req_is_load_i,
    input  logic                                core_req_is_store_i,
    input  logic                                core_req_is_uncacheable_i,
    input  logic                                core_req_need_rsp_i,
    input  logic                                refill_req_valid_i,
    output logic                                refill_req_ready_o,
    input  logic                                dir_init_ready_i,
    output logic                                dir_lookup_valid_o,
    output hpdcache_ctrl_pkg::hpdcache_req_id_t  dir_lookup_id_o,
    input  logic                                dir_hit_i,
    input  logic                                mshr_hit_i,
    input  logic                                mshr_full_i,
    output logic                                rsp_valid_o,
    output hpdcache_ctrl_pkg::hpdcache_req_id_t  rsp_id_o,
    output logic                                uc_req_valid_o,
    output hpdcache_ctrl_pkg::hpdcache_req_id_t  uc_req_id_o,
    input  logic                                uc_done_i,
    output logic                                miss_req_valid_o,
    output hpdcache_ctrl_pkg::hpdcache_req_id_t  miss_req_id_o,
    output logic                                data_write_o,
    output logic                                rtab_full_o,
    input  hpdcache_ctrl_pkg::hpdcache_evt_e     evt_sel_i,
    output logic [EVT_CNT_WIDTH-1:0]            evt_count_o
);
    import hpdcache_ctrl_pkg::*;

    hpdcache_req_t     core_req;
    hpdcache_evt_vec_t ctrl_evt;
    hpdcache_evt_vec_t evt_vec;
    logic              accept_en;
    logic              st2_busy;
    logic              stall_evt;
    logic              refill_accept;

    hpdcache_st1_if  st1_if ();
    hpdcache_rtab_if rtab_if ();

    assign core_req = '{
        id:             core_req_id_i,
        is_load:        core_req_is_load_i,
        is_store:       core_req_is_store_i,
        is_uncacheable: core_req_is_uncacheable_i,
        need_rsp:       core_req_need_rsp_i
    };

    assign refill_accept = refill_req_valid_i & refill_req_ready_o;
    assign rtab_full_o   = rtab_if.full;

    // Stall pulse comes from the arbiter
    always_comb begin
        evt_vec            = ctrl_evt;
        evt_vec[EVT_STALL] = stall_evt;
    end

    hpdcache_req_arbiter #(.RTAB_DEPTH(RTAB_DEPTH)) hpdcache_req_arbiter_inst (
        .clk_i, .rst_n_i, .core_req_valid_i,
        .core_req_i         (core_req),
        .core_req_ready_o, .refill_req_valid_i, .refill_req_ready_o,
        .accept_en_i        (accept_en),
        .st2_busy_i         (st2_busy),
        .stall_evt_o        (stall_evt),
        .lookup_valid_o     (dir_lookup_valid_o),
        .lookup_id_o        (dir_lookup_id_o),
        .rtab               (rtab_if.reader),
        .st1                (st1_if.producer)
    );

    hpdcache_st1_ctrl #(.REFILL_CYCLES(REFILL_CYCLES)) hpdcache_st1_ctrl_inst (
        .clk_i, .rst_n_i, .dir_init_ready_i,
        .refill_accept_i    (refill_accept),
        .dir_hit_i, .mshr_hit_i, .mshr_full_i, .uc_done_i,
        .st1                (st1_if.consumer),
        .rtab               (rtab_if.ctrl),
        .accept_en_o        (accept_en),
        .st2_busy_o         (st2_busy),
        .rsp_valid_o, .rsp_id_o, .uc_req_valid_o, .uc_req_id_o,
        .miss_req_valid_o, .miss_req_id_o, .data_write_o,
        .evt_o              (ctrl_evt)
    );

    hpdcache_rtab #(.RTAB_DEPTH(RTAB_DEPTH)) hpdcache_rtab_inst (
        .clk_i, .rst_n_i,
        .refill_accept_i    (refill_accept),
        .rtab               (rtab_if.fifo)
    );

    hpdcache_evt_counters #(.EVT_CNT_WIDTH(EVT_CNT_WIDTH)) hpdcache_evt_counters_inst (
        .clk_i, .rst_n_i,
        .evt_i              (evt_vec),
        .evt_sel_i, .evt_count_o
    );

endmodule

// ==== source/hpdcache_evt_counters.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Performance event counter bank
// One saturating counter per event, read back by select
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module hpdcache_evt_counters #(
    parameter int EVT_CNT_WIDTH = 16
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  hpdcache_ctrl_pkg::hpdcache_evt_vec_t evt_i,
    input  hpdcache_ctrl_pkg::hpdcache_evt_e     evt_sel_i,
    output logic [EVT_CNT_WIDTH-1:0]            evt_count_o
);
    import hpdcache_ctrl_pkg::*;

    logic [EVT_CNT_WIDTH-1:0] cnt_q [HPDCACHE_EVT_NUM];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < HPDCACHE_EVT_NUM; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < HPDCACHE_EVT_NUM; i++) begin
                // Stick at the top value
                if (evt_i[i] && cnt_q[i] != '1) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
        end
    end

    assign evt_count_o = cnt_q[evt_sel_i];

endmodule

// ==== source/hpdcache_rtab.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Replay table
// FIFO of requests on hold, each with a replay-ready mark
// Marks set by a refill, cleared on rollback of the head
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module hpdcache_rtab #(
    parameter int RTAB_DEPTH = 4
) (
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  logic          refill_accept_i,
    hpdcache_rtab_if.fifo rtab
);
    import hpdcache_ctrl_pkg::*;

    localparam int PTR_W = (RTAB_DEPTH > 1) ? $clog2(RTAB_DEPTH) : 1;
    localparam int CNT_W = $clog2(RTAB_DEPTH + 1);

    hpdcache_req_t         req_q [RTAB_DEPTH];
    logic [RTAB_DEPTH-1:0] rdy_q;
    logic [PTR_W-1:0]      wr_ptr_q;
    logic [PTR_W-1:0]      rd_ptr_q;
    logic [CNT_W-1:0]      cnt_q;

    // Wrap also for depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        ptr_inc = (ptr == PTR_W'(RTAB_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
            rdy_q    <= '0;
        end else begin
            // A refill may resolve any held request
            if (refill_accept_i) begin
                rdy_q <= '1;
            end
            if (rtab.alloc) begin
                rdy_q[wr_ptr_q] <= 1'b0;
                wr_ptr_q        <= ptr_inc(wr_ptr_q);
                cnt_q           <= cnt_q + 1'b1;
            end
            if (rtab.rback) begin
                rdy_q[rd_ptr_q] <= 1'b0;
            end
            if (rtab.commit) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
                cnt_q    <= cnt_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rtab.alloc) begin
            req_q[wr_ptr_q] <= rtab.req;
        end
    end

    // Head offered only while its mark is set
    assign rtab.head_valid = (cnt_q != '0) & rdy_q[rd_ptr_q];
    assign rtab.head_req   = req_q[rd_ptr_q];
    assign rtab.full       = (cnt_q == CNT_W'(RTAB_DEPTH));

    // Controller respects the fill state
    assert property (@(posedge clk_i) disable iff (!rst_n_i) rtab.alloc |-> !rtab.full);
    assert property (@(posedge clk_i) disable iff (!rst_n_i) rtab.commit |-> cnt_q != '0);

endmodule

// ==== source/hpdcache_st1_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stage-1 controller
// Init, refill and uncacheable wait state machine
// Stage-1 decisions, replay table strobes, stage-2 miss register
// Performance event pulses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module hpdcache_st1_ctrl #(
    parameter int REFILL_CYCLES = 4
) (
    input  logic                                   clk_i,
    input  logic                                   rst_n_i,
    input  logic                                   dir_init_ready_i,
    input  logic                                   refill_accept_i,
    input  logic                                   dir_hit_i,
    input  logic                                   mshr_hit_i,
    input  logic                                   mshr_full_i,
    input  logic                                   uc_done_i,
    hpdcache_st1_if.consumer                       st1,
    hpdcache_rtab_if.ctrl                          rtab,
    output logic                                   accept_en_o,
    output logic                                   st2_busy_o,
    output logic                                   rsp_valid_o,
    output hpdcache_ctrl_pkg::hpdcache_req_id_t     rsp_id_o,
    output logic                                   uc_req_valid_o,
    output hpdcache_ctrl_pkg::hpdcache_req_id_t     uc_req_id_o,
    output logic                                   miss_req_valid_o,
    output hpdcache_ctrl_pkg::hpdcache_req_id_t     miss_req_id_o,
    output logic                                   data_write_o,
    output hpdcache_ctrl_pkg::hpdcache_evt_vec_t    evt_o
);
    import hpdcache_ctrl_pkg::*;

    localparam int CNT_W = $clog2(REFILL_CYCLES + 1);

    hpdcache_st1_state_e state_q;
    hpdcache_st1_state_e state_d;
    logic [CNT_W-1:0]    refill_cnt_q;
    logic                st2_valid_q;
    hpdcache_req_id_t    st2_id_q;
    logic                st2_load;
    logic                miss;
    logic                blocked;

    assign miss = ~dir_hit_i;

    // Pending miss on the line, or no MSHR slot left for a load
    assign blocked = miss & ((st1.req.is_load & (mshr_hit_i | mshr_full_i)) |
                             (st1.req.is_store & mshr_hit_i));

    always_comb begin
        rsp_valid_o    = 1'b0;
        uc_req_valid_o = 1'b0;
        data_write_o   = 1'b0;
        st2_load       = 1'b0;
        rtab.alloc     = 1'b0;
        rtab.commit    = 1'b0;
        rtab.rback     = 1'b0;
        evt_o          = '0;

        if (st1.valid) begin
            if (st1.req.is_uncacheable) begin
                uc_req_valid_o      = 1'b1;
                evt_o[EVT_UNCACHED] = 1'b1;
            end else if (blocked) begin
                // Hold a new request, give a replayed one back
                rtab.alloc          = ~st1.from_rtab;
                rtab.rback          =  st1.from_rtab;
                evt_o[EVT_ON_HOLD]  = ~st1.from_rtab;
                evt_o[EVT_ROLLBACK] =  st1.from_rtab;
            end else begin
                // Every other outcome frees a replayed entry
                rtab.commit = st1.from_rtab;
                if (st1.req.is_load) begin
                    evt_o[EVT_READ] = 1'b1;
                    if (miss) begin
                        // Miss request goes out from stage 2
                        st2_load             = 1'b1;
                        evt_o[EVT_READ_MISS] = 1'b1;
                    end else begin
                        rsp_valid_o = st1.req.need_rsp;
                    end
                end else if (st1.req.is_store) begin
                    rsp_valid_o           = st1.req.need_rsp;
                    data_write_o          = dir_hit_i;
                    evt_o[EVT_WRITE]      = 1'b1;
                    evt_o[EVT_WRITE_MISS] = miss;
                end
            end
        end
    end

    assign rtab.req    = st1.req;
    assign rsp_id_o    = st1.req.id;
    assign uc_req_id_o = st1.req.id;

    assign miss_req_valid_o = st2_valid_q;
    assign miss_req_id_o    = st2_id_q;
    assign st2_busy_o       = st2_valid_q;
    // Stage 2 occupancy is the nop cycle after a miss
    assign accept_en_o      = (state_q == ST_RUN) & ~st2_valid_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_INIT: begin
                if (dir_init_ready_i) begin
                    state_d = ST_RUN;
                end
            end
            ST_RUN: begin
                if (refill_accept_i) begin
                    state_d = ST_REFILL;
                end else if (uc_req_valid_o) begin
                    state_d = ST_UC_WAIT;
                end
            end
            ST_REFILL: begin
                if (refill_cnt_q == '0) begin
                    state_d = ST_RUN;
                end
            end
            ST_UC_WAIT: begin
                if (uc_done_i) begin
                    state_d = ST_RUN;
                end
            end
            default: state_d = ST_INIT;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q      <= ST_INIT;
            refill_cnt_q <= '0;
            st2_valid_q  <= 1'b0;
        end else begin
            state_q     <= state_d;
            st2_valid_q <= st2_load;
            // Counts down the refill window
            if (refill_accept_i) begin
                refill_cnt_q <= CNT_W'(REFILL_CYCLES - 1);
            end else if (state_q == ST_REFILL && refill_cnt_q != '0) begin
                refill_cnt_q <= refill_cnt_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (st2_load) begin
            st2_id_q <= st1.req.id;
        end
    end

    // Uncacheable request only ever reaches stage 1 in run
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        uc_req_valid_o |-> state_q == ST_RUN);

endmodule

// ==== source/hpdcache_req_arbiter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Request arbiter
// Refill over replay over core priority, nop gating
// Stage-1 request register and directory lookup request
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module hpdcache_req_arbiter #(
    parameter int RTAB_DEPTH = 4
) (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    input  logic                               core_req_valid_i,
    input  hpdcache_ctrl_pkg::hpdcache_req_t    core_req_i,
    output logic                               core_req_ready_o,
    input  logic                               refill_req_valid_i,
    output logic                               refill_req_ready_o,
    input  logic                               accept_en_i,
    input  logic                               st2_busy_i,
    output logic                               stall_evt_o,
    output logic                               lookup_valid_o,
    output hpdcache_ctrl_pkg::hpdcache_req_id_t lookup_id_o,
    hpdcache_rtab_if.reader                    rtab,
    hpdcache_st1_if.producer                   st1
);
    import hpdcache_ctrl_pkg::*;

    localparam int CNT_W = $clog2(RTAB_DEPTH + 1);

    logic [CNT_W-1:0] rtab_cnt_q;
    logic             st1_hold;
    logic             last_slot;
    logic             rtab_gnt;
    logic             core_gnt;

    // Occupancy of the replay table, mirrored from its push and pop strobes
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rtab_cnt_q <= '0;
        end else if (rtab.alloc) begin
            rtab_cnt_q <= rtab_cnt_q + 1'b1;
        end else if (rtab.commit) begin
            rtab_cnt_q <= rtab_cnt_q - 1'b1;
        end
    end

    // Replayed or uncacheable request in stage 1 holds off new grants
    assign st1_hold = st1.valid & (st1.from_rtab | st1.req.is_uncacheable);

    // Core request in stage 1 may still take the last free slot
    assign last_slot = st1.valid & ~st1.from_rtab &
                       (rtab_cnt_q == CNT_W'(RTAB_DEPTH - 1));

    // Refill only on an empty pipeline
    assign refill_req_ready_o = refill_req_valid_i & accept_en_i &
                                ~st1.valid & ~st2_busy_i;

    assign rtab_gnt = rtab.head_valid & ~refill_req_valid_i & accept_en_i & ~st1_hold;

    // No combinational path from the directory results
    assign core_req_ready_o = ~rtab.head_valid & ~refill_req_valid_i & ~rtab.full &
                              ~last_slot & accept_en_i & ~st1_hold;

    assign core_gnt    = core_req_valid_i & core_req_ready_o;
    assign stall_evt_o = core_req_valid_i & ~core_req_ready_o;

    // Directory lookup issued in the grant cycle
    assign lookup_valid_o = core_gnt | rtab_gnt;
    assign lookup_id_o    = rtab_gnt ? rtab.head_req.id : core_req_i.id;

    // Stage-1 register, cleared when nothing is granted
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            st1.valid     <= 1'b0;
            st1.from_rtab <= 1'b0;
        end else begin
            st1.valid     <= core_gnt | rtab_gnt;
            st1.from_rtab <= rtab_gnt;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rtab_gnt) begin
            st1.req <= rtab.head_req;
        end else if (core_gnt) begin
            st1.req <= core_req_i;
        end
    end

    // Mirrored occupancy agrees with the fill flag of the table
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rtab.full == (rtab_cnt_q == CNT_W'(RTAB_DEPTH)));

endmodule

// ==== source/hpdcache_rtab_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Replay table bundle
// Controller side, table side and head reader for the arbiter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

interface hpdcache_rtab_if;
    import hpdcache_ctrl_pkg::*;

    // Stage-1 decisions, at most one per cycle
    logic          alloc;
    logic          commit;
    logic          rback;
    hpdcache_req_t req;

    // Head of the table and its fill state
    logic          head_valid;
    hpdcache_req_t head_req;
    logic          full;

    modport ctrl (output alloc, output commit, output rback, output req);

    modport fifo (
        input  alloc, input  commit, input  rback, input  req,
        output head_valid, output head_req, output full
    );

    // Arbiter also watches pushes and pops to track occupancy
    modport reader (input head_valid, input head_req, input full, input alloc, input commit);

endinterface

// ==== source/hpdcache_st1_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stage-1 request register bundle
// Producer side is the arbiter, consumers are the controller
// and the top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

interface hpdcache_st1_if;
    import hpdcache_ctrl_pkg::*;

    // Request present in stage 1
    logic          valid;
    hpdcache_req_t req;
    // Request came from the replay table
    logic          from_rtab;

    modport producer (
        output valid,
        output req,
        output from_rtab
    );

    modport consumer (
        input valid,
        input req,
        input from_rtab
    );

endinterface

// ==== source/hpdcache_ctrl_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared definitions of the data cache control engine
// Request type, controller states and performance events
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package hpdcache_ctrl_pkg;

    // Request identifier, echoed on responses and outgoing requests
    typedef logic [3:0] hpdcache_req_id_t;

    typedef struct packed {
        hpdcache_req_id_t id;
        logic             is_load;
        logic             is_store;
        logic             is_uncacheable;
        logic             need_rsp;
    } hpdcache_req_t;

    // Controller states
    typedef enum logic [1:0] {
        ST_INIT    = 2'd0,
        ST_RUN     = 2'd1,
        ST_REFILL  = 2'd2,
        ST_UC_WAIT = 2'd3
    } hpdcache_st1_state_e;

    // Performance events, one pulse bit each
    localparam int HPDCACHE_EVT_NUM = 8;

    typedef enum logic [2:0] {
        EVT_READ       = 3'd0,
        EVT_WRITE      = 3'd1,
        EVT_READ_MISS  = 3'd2,
        EVT_WRITE_MISS = 3'd3,
        EVT_UNCACHED   = 3'd4,
        EVT_ON_HOLD    = 3'd5,
        EVT_ROLLBACK   = 3'd6,
        EVT_STALL      = 3'd7
    } hpdcache_evt_e;

    typedef logic [HPDCACHE_EVT_NUM-1:0] hpdcache_evt_vec_t;

    // Cycles the refill owns the cache after its handshake
    localparam int REFILL_CYCLES_DEFAULT = 4;

endpackage
